// File: hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;

    // one data word or one byte address
    typedef logic [XLEN-1:0] word_t;

    // one enable bit per byte lane
    typedef logic [XLEN/8-1:0] byte_mask_t;

    // memory operation code from the execute stage
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LBU  = 4'd2,
        LH   = 4'd3,
        LHU  = 4'd4,
        LW   = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8,
        LR_W = 4'd9,
        SC_W = 4'd10,
        AMO  = 4'd11
    } mem_op_e;

    // read-modify-write function of an AMO
    typedef enum logic [3:0] {
        SWAP = 4'd0,
        ADD  = 4'd1,
        XOR  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        MIN  = 4'd5,
        MAX  = 4'd6,
        MINU = 4'd7,
        MAXU = 4'd8
    } amo_op_e;

    // access width
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } acc_size_e;

    // atomic sequencer
    typedef enum logic [1:0] {
        AMO_IDLE,
        AMO_LOAD,
        AMO_STORE,
        AMO_DONE
    } amo_state_e;

    // timer word offsets from the CLINT base
    localparam word_t CLINT_MTIME_OFFS     = 32'd0;
    localparam word_t CLINT_MTIMEH_OFFS    = 32'd4;
    localparam word_t CLINT_MTIMECMP_OFFS  = 32'd8;
    localparam word_t CLINT_MTIMECMPH_OFFS = 32'd12;

    // SC.W result when the reservation is lost
    localparam word_t SC_FAIL_CODE = 32'd1;

endpackage

`default_nettype wire

// File: hdl/lsu_decode.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_decode (
    input  lsu_pkg::mem_op_e   mem_op_i,
    output logic               is_load_o,
    output logic               is_store_o,
    output logic               is_lr_o,
    output logic               is_sc_o,
    output logic               is_amo_o,
    output lsu_pkg::acc_size_e size_o,
    output logic               sign_ext_o
);
    import lsu_pkg::*;

    always_comb begin
        // non-memory op sets no class and leaves the width unused
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        is_lr_o    = 1'b0;
        is_sc_o    = 1'b0;
        is_amo_o   = 1'b0;
        size_o     = WORD;
        sign_ext_o = 1'b0;
        case (mem_op_i)
            LB, LBU: begin
                is_load_o  = 1'b1;
                size_o     = BYTE;
                sign_ext_o = (mem_op_i == LB);
            end
            LH, LHU: begin
                is_load_o  = 1'b1;
                size_o     = HALF;
                sign_ext_o = (mem_op_i == LH);
            end
            LW: begin
                is_load_o  = 1'b1;
                sign_ext_o = 1'b1;
            end
            SB: begin
                is_store_o = 1'b1;
                size_o     = BYTE;
            end
            SH: begin
                is_store_o = 1'b1;
                size_o     = HALF;
            end
            SW: begin
                is_store_o = 1'b1;
            end
            // atomics are always full words
            LR_W: is_lr_o = 1'b1;
            SC_W: is_sc_o = 1'b1;
            AMO:  is_amo_o = 1'b1;
            default: begin
                is_load_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/lsu_align.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_align (
    input  lsu_pkg::acc_size_e  size_i,
    input  logic                sign_ext_i,
    input  logic [1:0]          byte_off_i,
    input  lsu_pkg::word_t      store_data_i,
    input  lsu_pkg::word_t      load_data_i,
    output lsu_pkg::byte_mask_t rmask_o,
    output lsu_pkg::byte_mask_t wmask_o,
    output lsu_pkg::word_t      wdata_o,
    output lsu_pkg::word_t      load_ext_o
);
    import lsu_pkg::*;

    byte_mask_t size_mask;
    logic       byte_sign;
    logic       half_sign;

    // lanes covered by the access, counted from lane 0
    always_comb begin
        case (size_i)
            BYTE:    size_mask = 4'b0001;
            HALF:    size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    // reads come back right-aligned, so the read mask stays unshifted
    assign rmask_o = size_mask;

    // writes move mask and data into the addressed lanes
    assign wmask_o = size_mask << byte_off_i;
    // offset in bytes times eight gives the bit shift
    assign wdata_o = store_data_i << {byte_off_i, 3'b000};

    // sign bits of the narrow load, zero for unsigned loads
    assign byte_sign = sign_ext_i & load_data_i[7];
    assign half_sign = sign_ext_i & load_data_i[15];

    always_comb begin
        case (size_i)
            BYTE: begin
                load_ext_o = {{(XLEN - 8){byte_sign}}, load_data_i[7:0]};
            end
            HALF: begin
                load_ext_o = {{(XLEN - 16){half_sign}}, load_data_i[15:0]};
            end
            default: begin
                // full word passes unchanged
                load_ext_o = load_data_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/lsu_amo_unit.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_amo_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_lr_i,
    input  logic             start_sc_i,
    input  logic             start_amo_i,
    input  lsu_pkg::amo_op_e amo_op_i,
    input  lsu_pkg::word_t   addr_i,
    input  lsu_pkg::word_t   rs2_i,
    input  logic             plain_store_done_i,
    input  logic             mem_ready_i,
    input  lsu_pkg::word_t   mem_rdata_i,
    output logic             req_o,
    output logic             we_o,
    output lsu_pkg::word_t   wdata_o,
    output lsu_pkg::word_t   result_o,
    output logic             done_o
);
    import lsu_pkg::*;

    amo_state_e state;
    amo_state_e state_next;

    // single reservation
    logic  res_valid;
    word_t res_addr;

    // word read in AMO_LOAD and value to write back
    word_t loaded_q;
    word_t new_q;
    logic  sc_pass_q;

    word_t amo_new;
    logic  sc_hit;
    logic  res_set;
    logic  res_clr;

    // SC.W succeeds only on a live reservation to the same word
    assign sc_hit = res_valid && (res_addr == addr_i);

    // new value from the word memory just returned
    always_comb begin
        case (amo_op_i)
            SWAP: amo_new = rs2_i;
            ADD:  amo_new = mem_rdata_i + rs2_i;
            XOR:  amo_new = mem_rdata_i ^ rs2_i;
            AND:  amo_new = mem_rdata_i & rs2_i;
            OR:   amo_new = mem_rdata_i | rs2_i;
            MIN:  amo_new = ($signed(mem_rdata_i) < $signed(rs2_i)) ? mem_rdata_i : rs2_i;
            MAX:  amo_new = ($signed(mem_rdata_i) > $signed(rs2_i)) ? mem_rdata_i : rs2_i;
            MINU: amo_new = (mem_rdata_i < rs2_i) ? mem_rdata_i : rs2_i;
            MAXU: amo_new = (mem_rdata_i > rs2_i) ? mem_rdata_i : rs2_i;
            default: amo_new = rs2_i;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            AMO_IDLE: begin
                if (start_lr_i || start_amo_i) begin
                    state_next = AMO_LOAD;
                end else if (start_sc_i) begin
                    // failed SC skips memory entirely
                    state_next = sc_hit ? AMO_STORE : AMO_DONE;
                end
            end
            AMO_LOAD: begin
                if (mem_ready_i) begin
                    state_next = start_lr_i ? AMO_DONE : AMO_STORE;
                end
            end
            AMO_STORE: begin
                if (mem_ready_i) begin
                    state_next = AMO_DONE;
                end
            end
            default: begin
                // one-cycle result slot
                state_next = AMO_IDLE;
            end
        endcase
    end

    // LR and AMO take the reservation on entry
    assign res_set = (state == AMO_IDLE) && (start_lr_i || start_amo_i);
    // SC and AMO drop it when they finish and so does any plain store
    assign res_clr = ((state == AMO_DONE) && (start_sc_i || start_amo_i)) || plain_store_done_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= AMO_IDLE;
            res_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (res_set) begin
                res_valid <= 1'b1;
            end else if (res_clr) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_set) begin
            res_addr <= addr_i;
        end
        // SC outcome sampled while the reservation is still intact
        if (state == AMO_IDLE) begin
            sc_pass_q <= sc_hit;
        end
        if ((state == AMO_LOAD) && mem_ready_i) begin
            loaded_q <= mem_rdata_i;
            new_q    <= amo_new;
        end
    end

    assign req_o   = (state == AMO_LOAD) || (state == AMO_STORE);
    assign we_o    = (state == AMO_STORE);
    // SC writes rs2 as is while AMO writes the computed value
    assign wdata_o = start_sc_i ? rs2_i : new_q;
    assign done_o  = (state == AMO_DONE);

    // LR and AMO both hand back the old memory word
    assign result_o = start_sc_i ? (sc_pass_q ? '0 : SC_FAIL_CODE) : loaded_q;

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_top #(
    parameter lsu_pkg::word_t CLINT_BASE = 32'h0200_4000
) (
    input  logic                clk,
    input  logic                rst,
    input  lsu_pkg::mem_op_e    mem_op_i,
    input  lsu_pkg::amo_op_e    amo_op_i,
    input  lsu_pkg::word_t      addr_i,
    input  lsu_pkg::word_t      rs2_i,
    output lsu_pkg::word_t      result_o,
    output logic                stall_o,
    output logic                amo_misalign_o,
    output logic                mem_req_o,
    output logic                mem_we_o,
    output lsu_pkg::word_t      mem_addr_o,
    output lsu_pkg::byte_mask_t mem_mask_o,
    output lsu_pkg::word_t      mem_wdata_o,
    input  logic                mem_ready_i,
    input  lsu_pkg::word_t      mem_rdata_i,
    output logic                clint_sel_o,
    output logic                clint_we_o,
    output lsu_pkg::word_t      clint_addr_o,
    output lsu_pkg::word_t      clint_wdata_o,
    input  lsu_pkg::word_t      clint_rdata_i
);
    import lsu_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       is_lr;
    logic       is_sc;
    logic       is_amo;
    logic       sign_ext;
    acc_size_e  size;
    logic       plain;
    logic       atomic;
    logic       amo_go;
    logic       clint_hit;
    logic       plain_req;
    byte_mask_t rmask;
    byte_mask_t wmask;
    word_t      st_wdata;
    word_t      load_src;
    word_t      load_ext;
    logic       amo_req;
    logic       amo_we;
    logic       amo_done;
    word_t      amo_wdata;
    word_t      amo_result;

    lsu_decode u_decode (
        .mem_op_i  (mem_op_i),
        .is_load_o (is_load),
        .is_store_o(is_store),
        .is_lr_o   (is_lr),
        .is_sc_o   (is_sc),
        .is_amo_o  (is_amo),
        .size_o    (size),
        .sign_ext_o(sign_ext)
    );

    assign plain  = is_load | is_store;
    assign atomic = is_lr | is_sc | is_amo;

    // four timer words sit at fixed offsets from the base
    assign clint_hit = (addr_i == CLINT_BASE + CLINT_MTIME_OFFS)
                     | (addr_i == CLINT_BASE + CLINT_MTIMEH_OFFS)
                     | (addr_i == CLINT_BASE + CLINT_MTIMECMP_OFFS)
                     | (addr_i == CLINT_BASE + CLINT_MTIMECMPH_OFFS);

    // atomics need word alignment and never go to the CLINT
    assign amo_misalign_o = atomic & (addr_i[1:0] != 2'b00);
    assign amo_go         = atomic & ~amo_misalign_o;
    assign plain_req      = plain & ~clint_hit;

    // same-cycle timer access on full words without a mask
    assign clint_sel_o   = plain & clint_hit;
    assign clint_we_o    = clint_sel_o & is_store;
    assign clint_addr_o  = addr_i;
    assign clint_wdata_o = rs2_i;

    // narrow load source picked before extension
    assign load_src = clint_sel_o ? clint_rdata_i : mem_rdata_i;

    lsu_align u_align (
        .size_i      (size),
        .sign_ext_i  (sign_ext),
        .byte_off_i  (addr_i[1:0]),
        .store_data_i(rs2_i),
        .load_data_i (load_src),
        .rmask_o     (rmask),
        .wmask_o     (wmask),
        .wdata_o     (st_wdata),
        .load_ext_o  (load_ext)
    );

    lsu_amo_unit u_amo (
        .clk               (clk),
        .rst               (rst),
        .start_lr_i        (is_lr & amo_go),
        .start_sc_i        (is_sc & amo_go),
        .start_amo_i       (is_amo & amo_go),
        .amo_op_i          (amo_op_i),
        .addr_i            (addr_i),
        .rs2_i             (rs2_i),
        .plain_store_done_i(is_store & (clint_hit | mem_ready_i)),
        .mem_ready_i       (mem_ready_i),
        .mem_rdata_i       (mem_rdata_i),
        .req_o             (amo_req),
        .we_o              (amo_we),
        .wdata_o           (amo_wdata),
        .result_o          (amo_result),
        .done_o            (amo_done)
    );

    // request drops in the ready cycle
    assign mem_req_o   = (plain_req | amo_req) & ~mem_ready_i;
    assign mem_we_o    = mem_req_o & (atomic ? amo_we : is_store);
    assign mem_addr_o  = addr_i;
    // atomics move whole words unshifted
    assign mem_mask_o  = atomic ? '1 : (is_store ? wmask : rmask);
    assign mem_wdata_o = atomic ? amo_wdata : st_wdata;

    // hold the pipeline until the plain access or the atomic sequence ends
    assign stall_o = (plain_req & ~mem_ready_i) | (amo_go & ~amo_done);

    // everything else passes the ALU value through
    assign result_o = atomic ? amo_result : (is_load ? load_ext : addr_i);

endmodule

`default_nettype wire

// File: tests/tb_lsu.sv
`default_nettype none
`timescale 1ns/1ps

module tb_lsu;
    import lsu_pkg::*;

    localparam word_t CLINT_BASE = 32'h0200_4000;
    localparam word_t SEED = 32'd10;
    // operations issued by all tests including the final idle
    localparam int NUM_OPS = 48;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 6 + 200;

    logic       clk;
    logic       rst;
    mem_op_e    mem_op;
    amo_op_e    amo_op;
    word_t      addr;
    word_t      rs2;
    word_t      result;
    logic       stall;
    logic       amo_misalign;
    logic       mem_req;
    logic       mem_we;
    word_t      mem_addr;
    byte_mask_t mem_mask;
    word_t      mem_wdata;
    logic       mem_ready = 1'b0;
    word_t      mem_rdata = '0;
    logic       clint_sel;
    logic       clint_we;
    word_t      clint_addr;
    word_t      clint_wdata;
    word_t      clint_rdata;

    // memory model, timer registers, random source
    word_t mem [256];
    word_t clint_regs [4];
    logic  pending;
    int    wait_left;
    word_t rng_state = SEED;

    // what the last operation did on the bus
    logic       saw_req;
    byte_mask_t wr_mask;
    word_t      wr_data;
    byte_mask_t rd_mask;
    int         op_cycles;
    int         n_checks = 0;
    int         n_errors = 0;

    lsu_top DUT (
        .clk           (clk),
        .rst           (rst),
        .mem_op_i      (mem_op),
        .amo_op_i      (amo_op),
        .addr_i        (addr),
        .rs2_i         (rs2),
        .result_o      (result),
        .stall_o       (stall),
        .amo_misalign_o(amo_misalign),
        .mem_req_o     (mem_req),
        .mem_we_o      (mem_we),
        .mem_addr_o    (mem_addr),
        .mem_mask_o    (mem_mask),
        .mem_wdata_o   (mem_wdata),
        .mem_ready_i   (mem_ready),
        .mem_rdata_i   (mem_rdata),
        .clint_sel_o   (clint_sel),
        .clint_we_o    (clint_we),
        .clint_addr_o  (clint_addr),
        .clint_wdata_o (clint_wdata),
        .clint_rdata_i (clint_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // xorshift32
    function automatic word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // timer block answers in the same cycle
    assign clint_rdata = clint_regs[clint_addr[3:2]];

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                clint_regs[i] <= '0;
            end
        end else if (clint_sel && clint_we) begin
            clint_regs[clint_addr[3:2]] <= clint_wdata;
        end
    end

    // memory with 0 to 3 wait cycles that completes the access on the edge raising ready
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_ready <= 1'b0;
            pending = 1'b0;
        end else if (mem_ready) begin
            // one-cycle ready pulse
            mem_ready <= 1'b0;
        end else if (mem_req) begin
            if (!pending) begin
                pending = 1'b1;
                wait_left = next_rand() % 4;
            end
            if (wait_left == 0) begin
                pending = 1'b0;
                mem_ready <= 1'b1;
                if (mem_we) begin
                    for (int k = 0; k < 4; k++) begin
                        if (mem_mask[k]) begin
                            mem[mem_addr[9:2]][8 * k +: 8] <= mem_wdata[8 * k +: 8];
                        end
                    end
                end else begin
                    // right-aligned read data
                    mem_rdata <= mem[mem_addr[9:2]] >> (8 * mem_addr[1:0]);
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL at %0t: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_mask(input byte_mask_t got, input byte_mask_t exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL at %0t: %s, got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL at %0t: %s, got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    // present one operation and sample each cycle mid-period until stall drops
    task automatic run_op(input mem_op_e op, input amo_op_e fn, input word_t ea,
                          input word_t operand);
        logic       prev_req;
        logic       prev_we;
        word_t      prev_addr;
        byte_mask_t prev_mask;
        word_t      prev_wdata;
        prev_req = 1'b0;
        @(posedge clk);
        mem_op <= op;
        amo_op <= fn;
        addr   <= ea;
        rs2    <= operand;
        saw_req   = 1'b0;
        op_cycles = 0;
        rd_mask   = '0;
        do begin
            @(negedge clk);
            op_cycles++;
            if (mem_req) begin
                saw_req = 1'b1;
                check_bit(stall, 1'b1, "stall_o high while request waits");
                // request fields frozen until ready
                if (prev_req) begin
                    check_bit(mem_we, prev_we, "mem_we_o stable");
                    check_word(mem_addr, prev_addr, "mem_addr_o stable");
                    check_mask(mem_mask, prev_mask, "mem_mask_o stable");
                    check_word(mem_wdata, prev_wdata, "mem_wdata_o stable");
                end
                if (mem_we) begin
                    wr_mask = mem_mask;
                    wr_data = mem_wdata;
                end else begin
                    rd_mask = mem_mask;
                end
            end
            prev_req   = mem_req;
            prev_we    = mem_we;
            prev_addr  = mem_addr;
            prev_mask  = mem_mask;
            prev_wdata = mem_wdata;
        end while (stall);
    endtask

    // low bytes of the stored value, widened by sign or zeros
    function automatic word_t expect_load(input word_t stored, input int nbytes,
                                          input logic signed_ld);
        word_t w;
        logic  neg;
        w   = '0;
        neg = signed_ld && stored[8 * nbytes - 1];
        for (int k = 0; k < 4; k++) begin
            if (k < nbytes) begin
                w[8 * k +: 8] = stored[8 * k +: 8];
            end else if (neg) begin
                w[8 * k +: 8] = 8'hff;
            end
        end
        return w;
    endfunction

    task automatic store_then_load(input int nbytes, input word_t ea);
        word_t      val;
        word_t      exp_word;
        word_t      lanes;
        byte_mask_t exp_mask;
        byte_mask_t exp_rmask;
        int         off;
        int         idx;
        mem_op_e    st_op;
        mem_op_e    ld_op;
        off = ea[1:0];
        idx = ea[9:2];
        val = next_rand();
        // upper offsets get a negative value
        val[8 * nbytes - 1] = (off >= 2);
        exp_word  = mem[idx];
        exp_mask  = '0;
        exp_rmask = '0;
        lanes     = '0;
        for (int k = 0; k < nbytes; k++) begin
            exp_word[8 * (off + k) +: 8] = val[8 * k +: 8];
            exp_mask[off + k] = 1'b1;
            exp_rmask[k] = 1'b1;
            lanes[8 * (off + k) +: 8] = 8'hff;
        end
        st_op = (nbytes == 1) ? SB : ((nbytes == 2) ? SH : SW);
        run_op(st_op, SWAP, ea, val);
        check_bit(saw_req, 1'b1, "store reaches memory");
        check_mask(wr_mask, exp_mask, "store byte mask");
        check_word(wr_data & lanes, exp_word & lanes, "store lane data");
        check_word(mem[idx], exp_word, "memory word after store");
        // signed form first and then unsigned where the width has one
        for (int s = 0; s < ((nbytes == 4) ? 1 : 2); s++) begin
            case (nbytes)
                1:       ld_op = s ? LBU : LB;
                2:       ld_op = s ? LHU : LH;
                default: ld_op = LW;
            endcase
            run_op(ld_op, SWAP, ea, next_rand());
            check_bit(mem_ready, 1'b1, "load ends in the ready cycle");
            check_mask(rd_mask, exp_rmask, "load byte mask");
            check_word(result, expect_load(val, nbytes, s == 0), "load data");
        end
    endtask

    task automatic load_store_sweep();
        for (int off = 0; off < 4; off++) begin
            store_then_load(1, 32'h100 + off);
        end
        for (int off = 0; off < 4; off += 2) begin
            store_then_load(2, 32'h104 + off);
        end
        store_then_load(4, 32'h108);
    endtask

    task automatic timer_access();
        word_t ea;
        word_t val;
        for (int i = 0; i < 4; i++) begin
            ea  = CLINT_BASE + 4 * i;
            val = next_rand();
            run_op(SW, SWAP, ea, val);
            check_bit(clint_sel, 1'b1, "timer store selects CLINT");
            check_bit(clint_we, 1'b1, "timer store write enable");
            check_bit(saw_req, 1'b0, "timer store skips memory");
            check_bit(op_cycles == 1, 1'b1, "timer store without stall");
            run_op(LW, SWAP, ea, '0);
            check_word(clint_regs[i], val, "timer register written");
            check_bit(clint_sel, 1'b1, "timer load selects CLINT");
            check_bit(clint_we, 1'b0, "timer load is a read");
            check_bit(saw_req, 1'b0, "timer load skips memory");
            check_bit(op_cycles == 1, 1'b1, "timer load without stall");
            check_word(result, val, "timer load data");
        end
        // non-memory op hands back the ALU value
        ea = next_rand();
        run_op(NONE, SWAP, ea, next_rand());
        check_word(result, ea, "pass-through result");
        check_bit(saw_req, 1'b0, "no request for non-memory op");
        check_bit(clint_sel, 1'b0, "no CLINT select for non-memory op");
        check_bit(op_cycles == 1, 1'b1, "non-memory op without stall");
    endtask

    // signs differ means the negative one is smaller
    function automatic word_t amo_expect(input amo_op_e fn, input word_t a, input word_t b);
        logic lt_u;
        logic lt_s;
        lt_u = a < b;
        lt_s = (a[31] != b[31]) ? a[31] : lt_u;
        case (fn)
            SWAP:    return b;
            ADD:     return a + b;
            XOR:     return a ^ b;
            AND:     return a & b;
            OR:      return a | b;
            MIN:     return lt_s ? a : b;
            MAX:     return lt_s ? b : a;
            MINU:    return lt_u ? a : b;
            MAXU:    return lt_u ? b : a;
            default: return b;
        endcase
    endfunction

    task automatic amo_case(input amo_op_e fn, input word_t ea);
        word_t old_word;
        word_t operand;
        int    idx;
        idx      = ea[9:2];
        old_word = next_rand();
        operand  = next_rand();
        // positive memory word against a negative operand
        if ((fn == MIN) || (fn == MAX) || (fn == MINU) || (fn == MAXU)) begin
            old_word[31] = 1'b0;
            operand[31]  = 1'b1;
        end
        mem[idx] = old_word;
        run_op(AMO, fn, ea, operand);
        check_bit(saw_req, 1'b1, "AMO reaches memory");
        check_mask(rd_mask, 4'b1111, "AMO reads the whole word");
        check_word(result, old_word, "AMO returns old word");
        check_word(mem[idx], amo_expect(fn, old_word, operand), "AMO new memory word");
    endtask

    task automatic amo_sweep();
        amo_op_e fns [9] = '{SWAP, ADD, XOR, AND, OR, MIN, MAX, MINU, MAXU};
        for (int i = 0; i < 9; i++) begin
            amo_case(fns[i], 32'h180 + 4 * i);
        end
    endtask

    task automatic lr_sc_sequence();
        word_t ea;
        word_t old_word;
        word_t v1;
        word_t v2;
        int    idx;
        ea       = 32'h200;
        idx      = ea[9:2];
        old_word = next_rand();
        v1       = next_rand();
        v2       = next_rand();
        mem[idx] = old_word;
        run_op(LR_W, SWAP, ea, '0);
        check_word(result, old_word, "LR.W returns memory word");
        run_op(SC_W, SWAP, ea, v1);
        check_word(result, 32'd0, "SC.W after LR.W succeeds");
        check_word(mem[idx], v1, "successful SC.W writes");
        // reservation used up
        run_op(SC_W, SWAP, ea, v2);
        check_word(result, 32'd1, "second SC.W fails");
        check_bit(saw_req, 1'b0, "failed SC.W makes no request");
        check_word(mem[idx], v1, "failed SC.W leaves memory");
        // plain store in between drops the reservation
        run_op(LR_W, SWAP, ea, '0);
        check_word(result, v1, "LR.W sees stored word");
        run_op(SW, SWAP, ea + 32'h10, v2);
        run_op(SC_W, SWAP, ea, v2);
        check_word(result, 32'd1, "SC.W after plain store fails");
        check_word(mem[idx], v1, "SC.W after plain store leaves memory");
    endtask

    task automatic misaligned_atomics();
        mem_op_e ops [3] = '{LR_W, SC_W, AMO};
        for (int i = 0; i < 3; i++) begin
            run_op(ops[i], ADD, 32'h300 + i + 1, next_rand());
            check_bit(amo_misalign, 1'b1, "misaligned atomic flagged");
            check_bit(saw_req, 1'b0, "misaligned atomic makes no request");
            check_bit(op_cycles == 1, 1'b1, "misaligned atomic without stall");
        end
    endtask

    initial begin
        rst    = 1'b1;
        mem_op = NONE;
        amo_op = SWAP;
        addr   = '0;
        rs2    = '0;
        // fill pattern mixes every address bit
        for (int i = 0; i < 256; i++) begin
            mem[i] = (word_t'(i) * 32'h9E37_79B9) ^ 32'hC3C3_0000;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        load_store_sweep();
        timer_access();
        amo_sweep();
        lr_sc_sequence();
        misaligned_atomics();
        // idle bus at the end
        run_op(NONE, SWAP, '0, '0);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_align.sv
hdl/lsu_amo_unit.sv
hdl/lsu_top.sv
tests/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_decode.sv
  - hdl/lsu_align.sv
  - hdl/lsu_amo_unit.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - tests/tb_lsu.sv
